// File: hw/cache_pkg.sv
package cache_pkg;

	localparam int word_size = 16;
	localparam int words_per_line = 4;
	localparam int num_lines = 4;
	localparam int tag_bits = 12;
	localparam int queue_depth = 4;
	localparam int mem_latency = 4;

	// one address word, seen either as cache fields or as a flat word address
	typedef union packed {
		logic [word_size-1:0] flat;
		struct packed {
			logic [tag_bits-1:0] tag;
			logic [$clog2(num_lines)-1:0] index;
			logic [$clog2(words_per_line)-1:0] offset;
		} f;
	} cache_addr_t;

	typedef struct packed {
		logic write;
		cache_addr_t addr;
		logic [word_size-1:0] wdata;
	} cache_req_t;

	// for a write, rdata carries the word that was written
	typedef struct packed {
		logic write;
		logic [word_size-1:0] rdata;
		logic hit;
	} cache_resp_t;

	typedef struct packed {
		logic read;
		logic write;
		cache_addr_t addr;
		logic [word_size-1:0] wdata;
	} mem_req_t;

	// word 0 of the line sits in the low bits
	typedef logic [words_per_line-1:0][word_size-1:0] line_t;

endpackage

// File: hw/req_queue.sv
`timescale 1ns/1ps

module req_queue (
	input logic clk,
	input logic reset_n,
	input logic push,
	input cache_pkg::cache_req_t push_req,
	input logic pop,
	output logic head_valid,
	output cache_pkg::cache_req_t head_req,
	output logic credit_return
);
	import cache_pkg::*;

	localparam int ptr_bits = $clog2(queue_depth);
	localparam int cnt_bits = $clog2(queue_depth + 1);

	cache_req_t entries_q [queue_depth];
	logic [ptr_bits-1:0] wr_ptr_q;
	logic [ptr_bits-1:0] rd_ptr_q;
	logic [cnt_bits-1:0] count_q;
	logic full;
	logic do_push;
	logic do_pop;

	assign full = (count_q == cnt_bits'(queue_depth));
	assign head_valid = (count_q != '0);
	assign head_req = entries_q[rd_ptr_q];

	// a push into a full queue breaks the credit protocol and is dropped here
	assign do_push = push && !full;
	assign do_pop = pop && head_valid;

	always_ff @(posedge clk) begin
		if (do_push) begin
			entries_q[wr_ptr_q] <= push_req;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
			credit_return <= 1'b0;
		end else begin
			credit_return <= do_pop;
			if (do_push) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (do_pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			if (do_push && !do_pop) begin
				count_q <= count_q + 1'b1;
			end else if (do_pop && !do_push) begin
				count_q <= count_q - 1'b1;
			end
		end
	end

endmodule

// File: hw/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl (
	input logic clk,
	input logic reset_n,
	input logic q_valid,
	input cache_pkg::cache_req_t q_req,
	output logic q_pop,
	output logic mem_valid,
	output cache_pkg::mem_req_t mem_req,
	input logic mem_done,
	input cache_pkg::line_t mem_line,
	output logic resp_valid,
	output cache_pkg::cache_resp_t resp,
	output logic [15:0] num_access,
	output logic [15:0] num_hit
);
	import cache_pkg::*;

	typedef enum logic [1:0] {
		idle,
		lookup,
		mem_wait,
		respond
	} state_t;

	state_t state_q;

	line_t lines_q [num_lines];
	logic [tag_bits-1:0] tag_q [num_lines];
	logic [num_lines-1:0] valid_q;

	cache_req_t req_q;
	mem_req_t mem_req_q;
	logic mem_valid_q;
	logic hit_q;
	logic [word_size-1:0] rdata_q;

	logic [$clog2(num_lines)-1:0] idx;
	logic [$clog2(words_per_line)-1:0] off;
	logic hit;

	assign idx = req_q.addr.f.index;
	assign off = req_q.addr.f.offset;
	assign hit = valid_q[idx] && (tag_q[idx] == req_q.addr.f.tag);

	// the head is taken only between requests
	assign q_pop = (state_q == idle) && q_valid;

	assign mem_valid = mem_valid_q;
	assign mem_req = mem_req_q;

	assign resp_valid = (state_q == respond);
	assign resp.write = req_q.write;
	assign resp.rdata = rdata_q;
	assign resp.hit = hit_q;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state_q <= idle;
			mem_valid_q <= 1'b0;
			valid_q <= '0;
			num_access <= '0;
			num_hit <= '0;
		end else begin
			mem_valid_q <= 1'b0;
			case (state_q)
				idle: begin
					if (q_valid) begin
						state_q <= lookup;
					end
				end
				lookup: begin
					num_access <= num_access + 1'b1;
					if (hit) begin
						num_hit <= num_hit + 1'b1;
					end
					// writes always go through to memory
					if (hit && !req_q.write) begin
						state_q <= respond;
					end else begin
						mem_valid_q <= 1'b1;
						state_q <= mem_wait;
					end
				end
				mem_wait: begin
					if (mem_done) begin
						if (!req_q.write) begin
							valid_q[idx] <= 1'b1;
						end
						state_q <= respond;
					end
				end
				default: begin
					state_q <= idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state_q)
			idle: begin
				if (q_valid) begin
					req_q <= q_req;
				end
			end
			lookup: begin
				hit_q <= hit;
				mem_req_q.read <= !req_q.write;
				mem_req_q.write <= req_q.write;
				mem_req_q.addr <= req_q.addr;
				mem_req_q.wdata <= req_q.wdata;
				if (req_q.write) begin
					rdata_q <= req_q.wdata;
				end else begin
					rdata_q <= lines_q[idx][off];
				end
				// a write hit keeps the line in step with memory
				if (hit && req_q.write) begin
					lines_q[idx][off] <= req_q.wdata;
				end
			end
			mem_wait: begin
				if (mem_done && !req_q.write) begin
					lines_q[idx] <= mem_line;
					tag_q[idx] <= req_q.addr.f.tag;
					rdata_q <= mem_line[off];
				end
			end
			default: begin
			end
		endcase
	end

endmodule

// File: hw/backing_mem.sv
`timescale 1ns/1ps

module backing_mem (
	input logic clk,
	input logic reset_n,
	input logic mem_valid,
	input cache_pkg::mem_req_t mem_req,
	output logic mem_done,
	output cache_pkg::line_t mem_line
);
	import cache_pkg::*;

	localparam int cnt_bits = $clog2(mem_latency + 1);

	logic [word_size-1:0] mem_q [2**word_size];
	mem_req_t req_q;
	logic busy_q;
	logic [cnt_bits-1:0] cnt_q;
	logic fire;
	logic [word_size-1:0] base;

	// each word holds the inverse of its own address
	initial begin
		for (int i = 0; i < 2**word_size; i++) begin
			mem_q[i] = ~word_size'(i);
		end
	end

	assign fire = busy_q && (cnt_q == cnt_bits'(1));
	assign base = req_q.addr.flat & ~word_size'(words_per_line - 1);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			busy_q <= 1'b0;
			cnt_q <= '0;
			mem_done <= 1'b0;
		end else begin
			mem_done <= fire;
			if (mem_valid) begin
				busy_q <= 1'b1;
				cnt_q <= cnt_bits'(mem_latency - 1);
			end else if (fire) begin
				busy_q <= 1'b0;
			end else if (busy_q) begin
				cnt_q <= cnt_q - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (mem_valid) begin
			req_q <= mem_req;
		end
		if (fire && req_q.read) begin
			for (int i = 0; i < words_per_line; i++) begin
				mem_line[i] <= mem_q[base + word_size'(i)];
			end
		end
		if (fire && req_q.write) begin
			mem_q[req_q.addr.flat] <= req_q.wdata;
		end
	end

endmodule

// File: hw/cache_top.sv
`timescale 1ns/1ps

module cache_top (
	input logic clk,
	input logic reset_n,
	input logic req_valid,
	input cache_pkg::cache_req_t req,
	output logic credit_return,
	output logic resp_valid,
	output cache_pkg::cache_resp_t resp,
	output logic [15:0] num_access,
	output logic [15:0] num_hit
);
	import cache_pkg::*;

	logic q_valid;
	cache_req_t q_req;
	logic q_pop;
	logic mem_valid;
	mem_req_t mem_req;
	logic mem_done;
	line_t mem_line;

	req_queue req_queue_inst (
		.clk(clk),
		.reset_n(reset_n),
		.push(req_valid),
		.push_req(req),
		.pop(q_pop),
		.head_valid(q_valid),
		.head_req(q_req),
		.credit_return(credit_return)
	);

	cache_ctrl cache_ctrl_inst (
		.clk(clk),
		.reset_n(reset_n),
		.q_valid(q_valid),
		.q_req(q_req),
		.q_pop(q_pop),
		.mem_valid(mem_valid),
		.mem_req(mem_req),
		.mem_done(mem_done),
		.mem_line(mem_line),
		.resp_valid(resp_valid),
		.resp(resp),
		.num_access(num_access),
		.num_hit(num_hit)
	);

	backing_mem backing_mem_inst (
		.clk(clk),
		.reset_n(reset_n),
		.mem_valid(mem_valid),
		.mem_req(mem_req),
		.mem_done(mem_done),
		.mem_line(mem_line)
	);

endmodule

// File: dv/cache_asserts.sv
`timescale 1ns/1ps

module cache_asserts (
	input logic clk,
	input logic reset_n,
	input logic req_valid,
	input logic credit_return,
	input logic q_pop,
	input logic resp_valid,
	input logic mem_valid,
	input logic mem_done
);
	import cache_pkg::*;

	// credits the requester holds, rebuilt from the traffic on the ports
	int held;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			held <= queue_depth;
		end else begin
			held <= held - int'(req_valid) + int'(credit_return);
		end
	end

	a_no_credit: assert property (@(posedge clk) disable iff (!reset_n)
		req_valid |-> (held > 0))
		else $error("request sent while the requester held no credit");

	a_credit_range: assert property (@(posedge clk) disable iff (!reset_n)
		(held >= 0) && (held <= queue_depth))
		else $error("credit count left the range zero to queue depth");

	a_credit_after_pop: assert property (@(posedge clk) disable iff (!reset_n)
		credit_return |-> $past(q_pop))
		else $error("credit returned without a preceding pop");

	// the first cycle out of reset must be quiet on every control output
	a_reset_quiet: assert property (@(posedge clk)
		(reset_n && $past(!reset_n)) |-> (!resp_valid && !credit_return && !q_pop && !mem_valid))
		else $error("control output high in the cycle after reset");

	a_mem_done_late: assert property (@(posedge clk) disable iff (!reset_n)
		mem_valid |-> ##mem_latency mem_done)
		else $error("memory operation did not finish after the fixed latency");

	a_mem_done_early: assert property (@(posedge clk) disable iff (!reset_n)
		mem_done |-> $past(mem_valid, mem_latency))
		else $error("memory done without a request the fixed latency earlier");

endmodule

// File: dv/cache_tb.sv
`timescale 1ns/1ps

module cache_tb;
	import cache_pkg::*;

	localparam int num_reqs = 51;
	localparam int timeout_cycles = num_reqs * (2 + mem_latency + 1 + queue_depth) + 200;

	logic clk;
	logic reset_n;
	logic req_valid;
	cache_req_t req;
	logic credit_return;
	logic resp_valid;
	cache_resp_t resp;
	logic [15:0] num_access;
	logic [15:0] num_hit;

	int credits;
	int errors;
	int checks;
	int cycles;
	int sent;
	int model_hits;
	logic [word_size-1:0] shadow [2**word_size];
	logic [tag_bits-1:0] exp_tag [num_lines];
	logic [num_lines-1:0] exp_valid;
	cache_resp_t exp_q [$];
	cache_resp_t exp_resp;

	cache_top cache_top_inst (
		.clk(clk),
		.reset_n(reset_n),
		.req_valid(req_valid),
		.req(req),
		.credit_return(credit_return),
		.resp_valid(resp_valid),
		.resp(resp),
		.num_access(num_access),
		.num_hit(num_hit)
	);

	bind cache_top cache_asserts cache_asserts_inst (
		.clk(clk),
		.reset_n(reset_n),
		.req_valid(req_valid),
		.credit_return(credit_return),
		.q_pop(q_pop),
		.resp_valid(resp_valid),
		.mem_valid(mem_valid),
		.mem_done(mem_done)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (credit_return) begin
			credits++;
		end
		if (resp_valid) begin
			checks++;
			if (exp_q.size() == 0) begin
				$display("ERROR at %0d ns: a response arrived with no request outstanding",
					$time);
				errors++;
			end else begin
				exp_resp = exp_q.pop_front();
				assert (resp == exp_resp) else begin
					$display({"FAILED at %0d ns: resp got write=%b rdata=%h hit=%b, ",
						"expected write=%b rdata=%h hit=%b"},
						$time, resp.write, resp.rdata, resp.hit,
						exp_resp.write, exp_resp.rdata, exp_resp.hit);
					errors++;
				end
			end
		end
		if (cycles >= timeout_cycles) begin
			$display("run stalled: %0d responses still missing after %0d cycles",
				exp_q.size(), cycles);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] want);
		checks++;
		assert (got == want) else begin
			$display("FAILED at %0d ns: %s got %h expected %h", $time, name, got, want);
			errors++;
		end
	endtask

	// predicts the response from the shadow memory and tag state, then drives the request
	task automatic send_req(input logic write, input logic [15:0] addr, input logic [15:0] data);
		cache_resp_t exp;
		logic [tag_bits-1:0] tag;
		logic [1:0] idx;
		while (credits == 0) begin
			req_valid = 1'b0;
			@(negedge clk);
		end
		idx = addr[3:2];
		tag = addr[15:4];
		exp.write = write;
		exp.hit = exp_valid[idx] && (exp_tag[idx] == tag);
		if (write) begin
			shadow[addr] = data;
			exp.rdata = data;
		end else begin
			exp.rdata = shadow[addr];
			exp_valid[idx] = 1'b1;
			exp_tag[idx] = tag;
		end
		if (exp.hit) begin
			model_hits++;
		end
		exp_q.push_back(exp);
		req_valid = 1'b1;
		req.write = write;
		req.addr.flat = addr;
		req.wdata = data;
		credits--;
		sent++;
		@(negedge clk);
		req_valid = 1'b0;
	endtask

	task automatic drain_responses();
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
		@(negedge clk);
	endtask

	task automatic report_test(input int num, input string name, input int errors_before);
		$display("test %0d %s: %0d errors", num, name, errors - errors_before);
	endtask

	initial begin
		int mark;
		logic [15:0] addr;
		void'($urandom(18));
		clk = 1'b0;
		reset_n = 1'b0;
		req_valid = 1'b0;
		req = '0;
		credits = queue_depth;
		errors = 0;
		checks = 0;
		cycles = 0;
		sent = 0;
		model_hits = 0;
		exp_valid = '0;
		for (int i = 0; i < num_lines; i++) begin
			exp_tag[i] = '0;
		end
		for (int i = 0; i < 2**word_size; i++) begin
			shadow[i] = ~word_size'(i);
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset_n = 1'b1;

		mark = errors;
		check_value("resp_valid", 16'(resp_valid), 16'h0);
		check_value("credit_return", 16'(credit_return), 16'h0);
		check_value("num_access", num_access, 16'h0);
		check_value("num_hit", num_hit, 16'h0);
		send_req(1'b0, 16'h1234, 16'h0);
		drain_responses();
		report_test(1, "reset and first miss", mark);

		mark = errors;
		send_req(1'b0, 16'h1234, 16'h0);
		send_req(1'b0, 16'h1235, 16'h0);
		drain_responses();
		report_test(2, "read hits in one line", mark);

		// one write lands on a cached line, the other on an uncached one
		mark = errors;
		send_req(1'b1, 16'h1236, 16'hbeef);
		send_req(1'b0, 16'h1236, 16'h0);
		send_req(1'b1, 16'h4000, 16'h5a5a);
		send_req(1'b0, 16'h4000, 16'h0);
		drain_responses();
		report_test(3, "write then read", mark);

		mark = errors;
		for (int i = 0; i < 4; i++) begin
			send_req(1'b0, (i % 2 == 0) ? 16'h0a08 : 16'h1b08, 16'h0);
		end
		drain_responses();
		report_test(4, "eviction on a shared index", mark);

		mark = errors;
		for (int i = 0; i < 40; i++) begin
			addr = 16'h2000 + 16'($urandom_range(63, 0));
			send_req($urandom_range(2, 0) == 0, addr, 16'($urandom));
		end
		drain_responses();
		check_value("num_access", num_access, 16'(sent));
		check_value("num_hit", num_hit, 16'(model_hits));
		report_test(5, "random burst and counters", mark);

		$display("tests run: 5, checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: project.f
hw/cache_pkg.sv
hw/req_queue.sv
hw/cache_ctrl.sv
hw/backing_mem.sv
hw/cache_top.sv
dv/cache_asserts.sv
dv/cache_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module cache_tb -f project.f -o cache_sim

status=0
./obj_dir/cache_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "RESULT: FAIL" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"
